/* files.f */
src/cpu_pkg.sv
src/reg_slot.sv
src/writeback_decode.sv
src/operand_select.sv
src/alu.sv
src/fetch_control.sv
src/cpu_core.sv
verif/cpu_core_chk.sv
verif/tb_cpu_core.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu_core -f files.f

out=$(./obj_dir/Vtb_cpu_core)
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

/* verif/tb_cpu_core.sv */
`default_nettype none

module tb_cpu_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 8;
    localparam int PROG_LEN     = 31;
    localparam int CYCLE_LIMIT  = 3 * PROG_LEN * 2 + RESET_CYCLES;

    // opcode values from the instruction set table
    localparam logic [5:0] C_ADD   = 6'd1;
    localparam logic [5:0] C_SUB   = 6'd2;
    localparam logic [5:0] C_AND   = 6'd3;
    localparam logic [5:0] C_OR    = 6'd4;
    localparam logic [5:0] C_XOR   = 6'd5;
    localparam logic [5:0] C_LOADI = 6'd6;
    localparam logic [5:0] C_STORE = 6'd7;
    localparam logic [5:0] C_LOAD  = 6'd8;
    localparam logic [5:0] C_CMPLT = 6'd9;
    localparam logic [5:0] C_BRF   = 6'd10;
    localparam logic [5:0] C_JMP   = 6'd11;

    logic        clear;
    logic        rst_n;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic [31:0] address;
    logic        rw;

    logic [31:0] mem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          cycles;
    int          stores_seen;
    integer      seed;

    cpu_core #(.NUM_REGS(8)) i_cpu_core (
        .clear    (clear),
        .rst_n    (rst_n),
        .data_in  (data_in),
        .data_out (data_out),
        .address  (address),
        .rw       (rw)
    );

    // combinational memory answer
    assign data_in = mem[address[7:0]];

    initial
    begin
        clear = 1'b0;
        forever #2 clear = ~clear;
    end

    function automatic logic [31:0] encode(input logic [5:0] op, input int dest, input int a,
                                           input int b, input logic hl, input logic [15:0] imm);
        logic [31:0] w;
        w = {imm, hl, 3'(dest), 3'(b), 3'(a), op};
        return w;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic load_program();
        logic [15:0] a_lo;
        logic [15:0] a_hi;
        logic [15:0] b_lo;
        logic [15:0] b_hi;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] ldv;
        for (int i = 0; i < 256; i++)
            mem[i] = 32'h5a00_0000 ^ (32'(i) * 32'h9e37_79b9);
        a_lo = 16'($random(seed));
        a_hi = 16'($random(seed)) & 16'h7fff;
        b_lo = 16'($random(seed));
        b_hi = 16'($random(seed)) | 16'h8000;
        ldv  = $random(seed);
        // a below b keeps the borrow and compare flags set
        va = {a_hi, a_lo};
        vb = {b_hi, b_lo};
        mem[8'ha0] = ldv;
        mem[0]  = encode(C_LOADI, 1, 1, 0, 1'b0, a_lo);
        mem[1]  = encode(C_LOADI, 1, 1, 0, 1'b1, a_hi);
        mem[2]  = encode(C_LOADI, 2, 2, 0, 1'b0, b_lo);
        mem[3]  = encode(C_LOADI, 2, 2, 0, 1'b1, b_hi);
        mem[4]  = encode(C_ADD, 3, 1, 2, 1'b0, 16'h0);
        mem[5]  = encode(C_STORE, 0, 3, 0, 1'b0, 16'h80);
        mem[6]  = encode(C_SUB, 4, 1, 2, 1'b0, 16'h0);
        mem[7]  = encode(C_STORE, 0, 4, 0, 1'b0, 16'h81);
        mem[8]  = encode(C_AND, 5, 1, 2, 1'b0, 16'h0);
        mem[9]  = encode(C_STORE, 0, 5, 0, 1'b0, 16'h82);
        mem[10] = encode(C_OR, 5, 1, 2, 1'b0, 16'h0);
        mem[11] = encode(C_STORE, 0, 5, 0, 1'b0, 16'h83);
        mem[12] = encode(C_XOR, 5, 1, 2, 1'b0, 16'h0);
        mem[13] = encode(C_STORE, 0, 5, 0, 1'b0, 16'h84);
        mem[14] = encode(C_STORE, 0, 1, 0, 1'b0, 16'h85);
        mem[15] = encode(C_LOAD, 6, 0, 0, 1'b0, 16'ha0);
        mem[16] = encode(C_STORE, 0, 6, 0, 1'b0, 16'h86);
        // borrow flag of r4 takes this branch
        mem[17] = encode(C_BRF, 0, 4, 0, 1'b0, 16'd20);
        mem[18] = encode(C_STORE, 0, 1, 0, 1'b0, 16'h8f);
        mem[19] = encode(C_STORE, 0, 1, 0, 1'b0, 16'h8f);
        mem[20] = encode(C_CMPLT, 7, 1, 2, 1'b0, 16'h0);
        mem[21] = encode(C_BRF, 0, 7, 0, 1'b0, 16'd24);
        mem[22] = encode(C_STORE, 0, 1, 0, 1'b0, 16'h8e);
        mem[23] = encode(C_STORE, 0, 1, 0, 1'b0, 16'h8e);
        // clear flag falls through
        mem[24] = encode(C_CMPLT, 0, 2, 1, 1'b0, 16'h0);
        mem[25] = encode(C_BRF, 0, 0, 0, 1'b0, 16'd30);
        mem[26] = encode(C_STORE, 0, 0, 0, 1'b0, 16'h87);
        mem[27] = encode(C_JMP, 0, 0, 0, 1'b0, 16'd29);
        mem[28] = encode(C_STORE, 0, 1, 0, 1'b0, 16'h8d);
        mem[29] = encode(C_STORE, 0, 7, 0, 1'b0, 16'h88);
        mem[30] = encode(C_JMP, 0, 0, 0, 1'b0, 16'd30);
        exp_addr = '{32'h80, 32'h81, 32'h82, 32'h83, 32'h84, 32'h85, 32'h86, 32'h87, 32'h88};
        exp_data = '{va + vb, va - vb, va & vb, va | vb, va ^ vb, va, ldv, vb, va};
    endtask

    // stores are checked and written away from the rising edge
    always @(negedge clear)
    begin
        if (rst_n && !rw)
        begin
            if (stores_seen >= exp_addr.size())
                fail_run($sformatf("unexpected extra store to address %h", address));
            else if (address !== exp_addr[stores_seen])
                fail_run($sformatf("MISMATCH time=%0t signal=address expected=%h got=%h",
                                   $time, exp_addr[stores_seen], address));
            else if (data_out !== exp_data[stores_seen])
                fail_run($sformatf("MISMATCH time=%0t signal=data_out expected=%h got=%h",
                                   $time, exp_data[stores_seen], data_out));
            else
            begin
                mem[address[7:0]] = data_out;
                stores_seen = stores_seen + 1;
            end
        end
    end

    always @(posedge clear)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
            fail_run("timeout: the program did not reach its final jump in time");
    end

    initial
    begin
        seed        = 32'h441a_cc40;
        rst_n       = 1'b0;
        cycles      = 0;
        stores_seen = 0;
        load_program();
        repeat (RESET_CYCLES) @(posedge clear);
        #1;
        rst_n = 1'b1;
        @(negedge clear);
        if (address !== 32'h0)
            fail_run($sformatf("MISMATCH time=%0t signal=address expected=%h got=%h",
                               $time, 32'h0, address));
        if (rw !== 1'b1)
            fail_run($sformatf("MISMATCH time=%0t signal=rw expected=1 got=%b", $time, rw));
        wait (stores_seen == exp_addr.size());
        @(negedge clear);
        while (address !== 32'd30)
            @(negedge clear);
        // the self jump keeps every phase on its own address
        repeat (6)
        begin
            @(negedge clear);
            if (address !== 32'd30)
                fail_run($sformatf("MISMATCH time=%0t signal=address expected=%h got=%h",
                                   $time, 32'd30, address));
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/cpu_core_chk.sv */
`default_nettype none

module cpu_core_chk (
    input wire logic            clear,
    input wire logic            rst_n,
    input wire cpu_pkg::phase_t phase,
    input wire cpu_pkg::addr_t  pc,
    input wire cpu_pkg::addr_t  address,
    input wire logic            rw
);

    timeunit 1ns;
    timeprecision 100ps;

    import cpu_pkg::*;

    // fetch, execute, update in a fixed ring
    phase_order_fetch: assert property (@(posedge clear) disable iff (!rst_n)
        phase == PH_FETCH |=> phase == PH_EXECUTE)
        else $error("phase after fetch is %0d", phase);

    phase_order_execute: assert property (@(posedge clear) disable iff (!rst_n)
        phase == PH_EXECUTE |=> phase == PH_UPDATE)
        else $error("phase after execute is %0d", phase);

    phase_order_update: assert property (@(posedge clear) disable iff (!rst_n)
        phase == PH_UPDATE |=> phase == PH_FETCH)
        else $error("phase after update is %0d", phase);

    write_only_in_execute: assert property (@(posedge clear) disable iff (!rst_n)
        !rw |-> phase == PH_EXECUTE)
        else $error("rw low outside execute");

    pc_moves_after_update: assert property (@(posedge clear) disable iff (!rst_n)
        pc != $past(pc) |-> $past(phase) == PH_UPDATE)
        else $error("pc changed outside update");

    fetch_uses_pc: assert property (@(posedge clear) disable iff (!rst_n)
        phase == PH_FETCH |-> address == pc)
        else $error("fetch address %h differs from pc %h", address, pc);

endmodule

bind cpu_core cpu_core_chk i_cpu_core_chk (
    .clear   (clear),
    .rst_n   (rst_n),
    .phase   (phase),
    .pc      (pc),
    .address (address),
    .rw      (rw)
);

`default_nettype wire

/* src/cpu_core.sv */
`default_nettype none

module cpu_core #(
    parameter int NUM_REGS = 8
) (
    input  wire logic           clear,
    input  wire logic           rst_n,
    input  wire cpu_pkg::word_t data_in,
    output cpu_pkg::word_t      data_out,
    output cpu_pkg::addr_t      address,
    output logic                rw
);

    import cpu_pkg::*;

    phase_t              phase;
    word_t               instr;
    addr_t               pc;
    word_t               operand_a;
    word_t               operand_b;
    logic                flag_a;
    word_t               result;
    logic                flag_result;
    logic                branch_taken;
    addr_t               branch_target;
    logic [NUM_REGS-1:0] slot_we;
    word_t               slot_data;
    logic                slot_flag;
    word_t               slot_values [NUM_REGS];
    logic [NUM_REGS-1:0] slot_flags;

    fetch_control i_fetch_control (
        .clear         (clear),
        .rst_n         (rst_n),
        .data_in       (data_in),
        .operand_a     (operand_a),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .phase         (phase),
        .instr         (instr),
        .pc            (pc),
        .address       (address),
        .rw            (rw),
        .data_out      (data_out)
    );

    alu i_alu (
        .clear         (clear),
        .rst_n         (rst_n),
        .phase         (phase),
        .instr         (instr),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .flag_a        (flag_a),
        .data_in       (data_in),
        .result        (result),
        .flag_result   (flag_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    writeback_decode #(.NUM_REGS(NUM_REGS)) i_writeback_decode (
        .phase       (phase),
        .instr       (instr),
        .result      (result),
        .flag_result (flag_result),
        .slot_we     (slot_we),
        .slot_data   (slot_data),
        .slot_flag   (slot_flag)
    );

    operand_select #(.NUM_REGS(NUM_REGS)) i_operand_select (
        .instr       (instr),
        .slot_values (slot_values),
        .slot_flags  (slot_flags),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .flag_a      (flag_a)
    );

    for (genvar i = 0; i < NUM_REGS; i++)
    begin : g_slot
        reg_slot i_reg_slot (
            .clear   (clear),
            .rst_n   (rst_n),
            .we      (slot_we[i]),
            .data_in (slot_data),
            .flag_in (slot_flag),
            .value   (slot_values[i]),
            .flag    (slot_flags[i])
        );
    end

endmodule

`default_nettype wire

/* src/fetch_control.sv */
`default_nettype none

module fetch_control (
    input  wire logic           clear,
    input  wire logic           rst_n,
    input  wire cpu_pkg::word_t data_in,
    input  wire cpu_pkg::word_t operand_a,
    input  wire logic           branch_taken,
    input  wire cpu_pkg::addr_t branch_target,
    output cpu_pkg::phase_t     phase,
    output cpu_pkg::word_t      instr,
    output cpu_pkg::addr_t      pc,
    output cpu_pkg::addr_t      address,
    output logic                rw,
    output cpu_pkg::word_t      data_out
);

    import cpu_pkg::*;

    opcode_t opcode;
    addr_t   mem_addr;

    assign opcode   = opcode_t'(instr[OPC_LSB +: OPC_W]);
    assign mem_addr = addr_t'(imm_t'(instr[IMM_LSB +: IMM_W]));

    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase <= PH_FETCH;
            pc    <= '0;
            instr <= '0;
        end
        else
        begin
            case (phase)
                PH_FETCH:
                begin
                    instr <= data_in;
                    phase <= PH_EXECUTE;
                end
                PH_EXECUTE:
                    phase <= PH_UPDATE;
                PH_UPDATE:
                begin
                    pc    <= branch_taken ? branch_target : pc + addr_t'(1);
                    phase <= PH_FETCH;
                end
                default:
                    phase <= PH_FETCH;
            endcase
        end
    end

    // memory port follows the pc except for a load or store in execute
    always_comb
    begin
        address = pc;
        rw      = 1'b1;
        if (phase == PH_EXECUTE)
        begin
            if (opcode == OP_LOAD || opcode == OP_STORE)
                address = mem_addr;
            if (opcode == OP_STORE)
                rw = 1'b0;
        end
    end

    assign data_out = operand_a;

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

module alu (
    input  wire logic            clear,
    input  wire logic            rst_n,
    input  wire cpu_pkg::phase_t phase,
    input  wire cpu_pkg::word_t  instr,
    input  wire cpu_pkg::word_t  operand_a,
    input  wire cpu_pkg::word_t  operand_b,
    input  wire logic            flag_a,
    input  wire cpu_pkg::word_t  data_in,
    output cpu_pkg::word_t       result,
    output logic                 flag_result,
    output logic                 branch_taken,
    output cpu_pkg::addr_t       branch_target
);

    import cpu_pkg::*;

    opcode_t           opcode;
    imm_t              imm;
    logic              high_low;
    logic [WORD_W:0]   sum;
    logic [WORD_W:0]   diff;
    logic              take_branch;

    assign opcode   = opcode_t'(instr[OPC_LSB +: OPC_W]);
    assign imm      = instr[IMM_LSB +: IMM_W];
    assign high_low = instr[HL_BIT];

    // extra top bit holds carry out and borrow
    assign sum  = {1'b0, operand_a} + {1'b0, operand_b};
    assign diff = {1'b0, operand_a} - {1'b0, operand_b};

    always_comb
    begin
        result      = '0;
        flag_result = 1'b0;
        case (opcode)
            OP_ADD:
            begin
                result      = sum[WORD_W-1:0];
                flag_result = sum[WORD_W];
            end
            OP_SUB:
            begin
                result      = diff[WORD_W-1:0];
                flag_result = diff[WORD_W];
            end
            OP_AND: result = operand_a & operand_b;
            OP_OR:  result = operand_a | operand_b;
            OP_XOR: result = operand_a ^ operand_b;
            OP_LOADI:
            begin
                if (high_low)
                    result = {imm, operand_a[IMM_W-1:0]};
                else
                    result = {operand_a[WORD_W-1:IMM_W], imm};
            end
            OP_LOAD: result = data_in;
            OP_CMPLT:
            begin
                result      = operand_a;
                flag_result = operand_a < operand_b;
            end
            default: result = '0;
        endcase
    end

    assign take_branch   = (opcode == OP_JMP) || (opcode == OP_BRF && flag_a);
    assign branch_target = addr_t'(imm);

    // decision held for the update phase
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
            branch_taken <= 1'b0;
        else if (phase == PH_EXECUTE)
            branch_taken <= take_branch;
    end

endmodule

`default_nettype wire

/* src/operand_select.sv */
`default_nettype none

module operand_select #(
    parameter int NUM_REGS = 8
) (
    input  wire cpu_pkg::word_t instr,
    input  wire cpu_pkg::word_t slot_values [NUM_REGS],
    input  wire logic [NUM_REGS-1:0] slot_flags,
    output cpu_pkg::word_t      operand_a,
    output cpu_pkg::word_t      operand_b,
    output logic                flag_a
);

    import cpu_pkg::*;

    reg_idx_t src_a;
    reg_idx_t src_b;

    assign src_a = instr[SRCA_LSB +: REG_W];
    assign src_b = instr[SRCB_LSB +: REG_W];

    // register fields wrap when fewer than eight slots are built
    always_comb
    begin
        int sel_a;
        int sel_b;
        sel_a     = int'(src_a) % NUM_REGS;
        sel_b     = int'(src_b) % NUM_REGS;
        operand_a = slot_values[sel_a];
        operand_b = slot_values[sel_b];
        flag_a    = slot_flags[sel_a];
    end

endmodule

`default_nettype wire

/* src/writeback_decode.sv */
`default_nettype none

module writeback_decode #(
    parameter int NUM_REGS = 8
) (
    input  wire cpu_pkg::phase_t phase,
    input  wire cpu_pkg::word_t  instr,
    input  wire cpu_pkg::word_t  result,
    input  wire logic            flag_result,
    output logic [NUM_REGS-1:0]  slot_we,
    output cpu_pkg::word_t       slot_data,
    output logic                 slot_flag
);

    import cpu_pkg::*;

    opcode_t  opcode;
    reg_idx_t dest;
    logic     writes_reg;

    assign opcode = opcode_t'(instr[OPC_LSB +: OPC_W]);
    assign dest   = instr[DEST_LSB +: REG_W];

    always_comb
    begin
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_LOADI, OP_LOAD, OP_CMPLT: writes_reg = 1'b1;
            default:                     writes_reg = 1'b0;
        endcase
    end

    // one-hot enable, destination wraps modulo the slot count
    always_comb
    begin
        slot_we = '0;
        if (phase == PH_EXECUTE && writes_reg)
            slot_we[int'(dest) % NUM_REGS] = 1'b1;
    end

    assign slot_data = result;
    assign slot_flag = flag_result;

endmodule

`default_nettype wire

/* src/reg_slot.sv */
`default_nettype none

module reg_slot (
    input  wire logic          clear,
    input  wire logic          rst_n,
    input  wire logic          we,
    input  wire cpu_pkg::word_t data_in,
    input  wire logic          flag_in,
    output cpu_pkg::word_t     value,
    output logic               flag
);

    import cpu_pkg::*;

    // value and flag always load as a pair
    always_ff @(posedge clear or negedge rst_n)
    begin
        if (!rst_n)
        begin
            value <= '0;
            flag  <= 1'b0;
        end
        else if (we)
        begin
            value <= data_in;
            flag  <= flag_in;
        end
    end

endmodule

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int WORD_W = 32;
    localparam int OPC_W  = 6;
    localparam int REG_W  = 3;
    localparam int IMM_W  = 16;

    // instruction field positions
    localparam int OPC_LSB  = 0;
    localparam int SRCA_LSB = 6;
    localparam int SRCB_LSB = 9;
    localparam int DEST_LSB = 12;
    localparam int HL_BIT   = 15;
    localparam int IMM_LSB  = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W-1:0] addr_t;
    typedef logic [IMM_W-1:0]  imm_t;
    typedef logic [REG_W-1:0]  reg_idx_t;

    // codes not listed here decode as a nop
    typedef enum logic [OPC_W-1:0] {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_LOADI = 6'd6,
        OP_STORE = 6'd7,
        OP_LOAD  = 6'd8,
        OP_CMPLT = 6'd9,
        OP_BRF   = 6'd10,
        OP_JMP   = 6'd11
    } opcode_t;

    typedef enum logic [1:0] {
        PH_FETCH   = 2'd0,
        PH_EXECUTE = 2'd1,
        PH_UPDATE  = 2'd2
    } phase_t;

endpackage

`default_nettype wire
